//--- sa_cfg_pkg.sv
// Attention engine configuration
package sa_cfg_pkg;

    // Default square dimension, also the largest one the widths cover
    localparam int DIM_DEFAULT = 8;

    // Input elements of X and the three weight matrices
    localparam int ELEM_W = 8;

    // 8b x 8b products summed over 8 lanes
    localparam int QKV_W = 19;

    // Q row times K row before ReLU and scaling
    localparam int SCORE_W = 41;

    localparam int OUT_W = 64;

    // Row and column index width for up to 8 entries
    localparam int IDX_W = 3;

    // Valid-row count, 1 to DIM
    localparam int T_W = 4;

    // Multiply-add tree is built for eight lanes, unused lanes see zero
    localparam int TREE_LANES = 8;

endpackage

//--- sa_types_pkg.sv
// Attention engine shared types
package sa_types_pkg;

    import sa_cfg_pkg::*;

    typedef logic signed [ELEM_W-1:0]  elem_t;
    typedef logic signed [QKV_W-1:0]   qkv_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic signed [OUT_W-1:0]   out_t;
    typedef logic [IDX_W-1:0]          idx_t;

    // LOAD_K computes Q, LOAD_V computes K, CALC_V computes V
    typedef enum logic [2:0] {
        IDLE,
        LOAD_Q,
        LOAD_K,
        LOAD_V,
        CALC_V,
        SCORE,
        EMIT
    } phase_e;

    // One registered input beat
    typedef struct packed {
        elem_t x;
        elem_t w_q;
        elem_t w_k;
        elem_t w_v;
    } in_beat_t;

    typedef struct packed {
        phase_e phase;
        idx_t   row;
        idx_t   col;
        idx_t   wr_row;
        idx_t   wr_col;
        logic   clear;
    } ctrl_t;

    // One write enable per store
    typedef struct packed {
        logic x;
        logic w_q;
        logic w_k;
        logic w_v;
        logic q;
        logic k;
        logic v;
        logic s;
    } we_t;

endpackage

//--- matrix_store.sv
// Square register matrix
`timescale 1ns/1ps

module matrix_store #(
    parameter int  DIM       = 8,
    parameter type payload_t = sa_types_pkg::elem_t
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               we,
    input  sa_types_pkg::idx_t wr_row,
    input  sa_types_pkg::idx_t wr_col,
    input  payload_t           wr_data,
    input  sa_types_pkg::idx_t rd_row,
    input  sa_types_pkg::idx_t rd_col,
    output payload_t           row_vec [DIM],
    output payload_t           col_vec [DIM]
);
    import sa_types_pkg::*;

    payload_t mem [DIM][DIM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    mem[r][c] <= '0;
                end
            end
        end else if (clear) begin
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    mem[r][c] <= '0;
                end
            end
        end else if (we) begin
            mem[wr_row][wr_col] <= wr_data;
        end
    end

    // Write data is forwarded so a read in the write cycle sees the new value
    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            row_vec[i] = mem[rd_row][i];
            col_vec[i] = mem[i][rd_col];
            if (we && wr_row == rd_row && wr_col == idx_t'(i)) begin
                row_vec[i] = wr_data;
            end
            if (we && wr_col == rd_col && wr_row == idx_t'(i)) begin
                col_vec[i] = wr_data;
            end
        end
    end

endmodule

//--- dot_product_unit.sv
// Shared multiply-add tree
`timescale 1ns/1ps

module dot_product_unit #(
    parameter int DIM = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sa_types_pkg::ctrl_t  ctrl,
    input  sa_types_pkg::elem_t  x_row  [DIM],
    input  sa_types_pkg::elem_t  wq_col [DIM],
    input  sa_types_pkg::elem_t  wk_col [DIM],
    input  sa_types_pkg::elem_t  wv_col [DIM],
    input  sa_types_pkg::qkv_t   q_row  [DIM],
    input  sa_types_pkg::qkv_t   k_row  [DIM],
    input  sa_types_pkg::qkv_t   v_col  [DIM],
    input  sa_types_pkg::score_t s_row  [DIM],
    output sa_types_pkg::out_t   prod,
    output sa_types_pkg::score_t score
);
    import sa_cfg_pkg::*;
    import sa_types_pkg::*;

    score_t a_op [TREE_LANES];
    qkv_t   b_op [TREE_LANES];
    out_t   lane [TREE_LANES];
    out_t   pair [TREE_LANES/2];
    out_t   quad [TREE_LANES/4];
    out_t   sum;
    out_t   acc_q;
    phase_e phase_q;
    score_t raw_score;
    score_t relu_div3;

    // Operand pairs by phase
    always_comb begin
        for (int i = 0; i < TREE_LANES; i++) begin
            a_op[i] = '0;
            b_op[i] = '0;
        end
        for (int i = 0; i < DIM; i++) begin
            case (ctrl.phase)
                LOAD_K: begin
                    a_op[i] = score_t'(x_row[i]);
                    b_op[i] = qkv_t'(wq_col[i]);
                end
                LOAD_V: begin
                    a_op[i] = score_t'(x_row[i]);
                    b_op[i] = qkv_t'(wk_col[i]);
                end
                CALC_V: begin
                    a_op[i] = score_t'(x_row[i]);
                    b_op[i] = qkv_t'(wv_col[i]);
                end
                SCORE: begin
                    a_op[i] = score_t'(q_row[i]);
                    b_op[i] = k_row[i];
                end
                EMIT: begin
                    a_op[i] = s_row[i];
                    b_op[i] = v_col[i];
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < TREE_LANES; i++) begin
            lane[i] = out_t'(a_op[i]) * out_t'(b_op[i]);
        end
        for (int i = 0; i < TREE_LANES/2; i++) begin
            pair[i] = lane[2*i] + lane[2*i+1];
        end
        for (int i = 0; i < TREE_LANES/4; i++) begin
            quad[i] = pair[2*i] + pair[2*i+1];
        end
        sum = quad[0] + quad[1];
    end

    always_ff @(posedge clk) begin
        acc_q <= sum;
    end

    // Output register only loads in EMIT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= IDLE;
            prod    <= '0;
        end else begin
            phase_q <= ctrl.phase;
            prod    <= (ctrl.phase == EMIT) ? sum : '0;
        end
    end

    assign raw_score = score_t'(acc_q);
    assign relu_div3 = raw_score[SCORE_W-1] ? '0 : raw_score / score_t'(3);

    // Store write data, scaled only for scores
    assign score = (phase_q == SCORE) ? relu_div3 : raw_score;

endmodule

//--- sa_ctrl.sv
// Attention job controller
`timescale 1ns/1ps

module sa_ctrl #(
    parameter int DIM = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic [sa_cfg_pkg::T_W-1:0] t,
    output sa_types_pkg::ctrl_t        ctrl,
    output sa_types_pkg::we_t          we,
    output logic                       out_valid
);
    import sa_cfg_pkg::*;
    import sa_types_pkg::*;

    localparam idx_t DIM_LAST = idx_t'(DIM - 1);

    phase_e         phase, phase_n;
    phase_e         phase_d;
    idx_t           row, row_n;
    idx_t           col, col_n;
    idx_t           wr_row, wr_col;
    idx_t           row_last, col_last;
    logic [T_W-1:0] t_q;
    logic           start;

    assign start = (phase == IDLE) && in_valid;

    // Score loop is T by T, output loop is T rows of DIM
    always_comb begin
        col_last = (phase == SCORE) ? idx_t'(t_q - 1'b1) : DIM_LAST;
        row_last = (phase == SCORE || phase == EMIT) ? idx_t'(t_q - 1'b1) : DIM_LAST;
    end

    always_comb begin
        phase_n = phase;
        row_n   = row;
        col_n   = col;
        if (phase == IDLE) begin
            if (in_valid) begin
                // Beat 0 is taken in IDLE
                phase_n = LOAD_Q;
                col_n   = idx_t'(1);
            end
        end else if (col == col_last) begin
            col_n = '0;
            if (row == row_last) begin
                row_n = '0;
                case (phase)
                    LOAD_Q:  phase_n = LOAD_K;
                    LOAD_K:  phase_n = LOAD_V;
                    LOAD_V:  phase_n = CALC_V;
                    CALC_V:  phase_n = SCORE;
                    SCORE:   phase_n = EMIT;
                    default: phase_n = IDLE;
                endcase
            end else begin
                row_n = row + 1'b1;
            end
        end else begin
            col_n = col + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= IDLE;
            phase_d   <= IDLE;
            row       <= '0;
            col       <= '0;
            wr_row    <= '0;
            wr_col    <= '0;
            t_q       <= '0;
            out_valid <= 1'b0;
        end else begin
            phase     <= phase_n;
            phase_d   <= start ? LOAD_Q : phase;
            row       <= row_n;
            col       <= col_n;
            wr_row    <= row;
            wr_col    <= col;
            out_valid <= (phase == EMIT);
            if (start) begin
                t_q <= t;
            end
        end
    end

    always_comb begin
        ctrl.phase  = phase;
        ctrl.row    = row;
        ctrl.col    = col;
        ctrl.wr_row = wr_row;
        ctrl.wr_col = wr_col;
        ctrl.clear  = start;
    end

    // Writes follow the read phase by one cycle
    always_comb begin
        we = '0;
        case (phase_d)
            LOAD_Q: begin
                // X rows at or beyond T keep their cleared zero
                we.x   = T_W'(wr_row) < t_q;
                we.w_q = 1'b1;
            end
            LOAD_K: begin
                we.w_k = 1'b1;
                we.q   = 1'b1;
            end
            LOAD_V: begin
                we.w_v = 1'b1;
                we.k   = 1'b1;
            end
            CALC_V:  we.v = 1'b1;
            SCORE:   we.s = 1'b1;
            default: begin
            end
        endcase
    end

endmodule

//--- sa_top.sv
// Self-attention engine top
`timescale 1ns/1ps

module sa_top #(
    parameter int DIM = sa_cfg_pkg::DIM_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic [sa_cfg_pkg::T_W-1:0] t,
    input  sa_types_pkg::elem_t        in_data,
    input  sa_types_pkg::elem_t        w_q,
    input  sa_types_pkg::elem_t        w_k,
    input  sa_types_pkg::elem_t        w_v,
    output logic                       out_valid,
    output sa_types_pkg::out_t         out_data
);
    import sa_types_pkg::*;

    in_beat_t beat_q;
    ctrl_t    ctrl;
    we_t      we;
    elem_t    x_row  [DIM];
    elem_t    wq_col [DIM];
    elem_t    wk_col [DIM];
    elem_t    wv_col [DIM];
    qkv_t     q_row  [DIM];
    qkv_t     k_row  [DIM];
    qkv_t     v_col  [DIM];
    score_t   s_row  [DIM];
    score_t   score;

    // Input beat register
    always_ff @(posedge clk) begin
        beat_q <= '{x: in_data, w_q: w_q, w_k: w_k, w_v: w_v};
    end

    sa_ctrl #(.DIM(DIM)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t(t),
        .ctrl(ctrl), .we(we), .out_valid(out_valid)
    );

    matrix_store #(.DIM(DIM), .payload_t(elem_t)) u_x (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.x),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(beat_q.x),
        .rd_row(ctrl.row), .rd_col(ctrl.col), .row_vec(x_row), .col_vec()
    );

    matrix_store #(.DIM(DIM), .payload_t(elem_t)) u_wq (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.w_q),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(beat_q.w_q),
        .rd_row(ctrl.row), .rd_col(ctrl.col), .row_vec(), .col_vec(wq_col)
    );

    matrix_store #(.DIM(DIM), .payload_t(elem_t)) u_wk (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.w_k),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(beat_q.w_k),
        .rd_row(ctrl.row), .rd_col(ctrl.col), .row_vec(), .col_vec(wk_col)
    );

    matrix_store #(.DIM(DIM), .payload_t(elem_t)) u_wv (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.w_v),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(beat_q.w_v),
        .rd_row(ctrl.row), .rd_col(ctrl.col), .row_vec(), .col_vec(wv_col)
    );

    matrix_store #(.DIM(DIM), .payload_t(qkv_t)) u_q (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.q),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(qkv_t'(score)),
        .rd_row(ctrl.row), .rd_col(ctrl.col), .row_vec(q_row), .col_vec()
    );

    // Score column j reads K row j
    matrix_store #(.DIM(DIM), .payload_t(qkv_t)) u_k (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.k),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(qkv_t'(score)),
        .rd_row(ctrl.col), .rd_col(ctrl.col), .row_vec(k_row), .col_vec()
    );

    matrix_store #(.DIM(DIM), .payload_t(qkv_t)) u_v (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.v),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(qkv_t'(score)),
        .rd_row(ctrl.row), .rd_col(ctrl.col), .row_vec(), .col_vec(v_col)
    );

    matrix_store #(.DIM(DIM), .payload_t(score_t)) u_s (
        .clk(clk), .rst_n(rst_n), .clear(ctrl.clear), .we(we.s),
        .wr_row(ctrl.wr_row), .wr_col(ctrl.wr_col), .wr_data(score),
        .rd_row(ctrl.row), .rd_col(ctrl.col), .row_vec(s_row), .col_vec()
    );

    dot_product_unit #(.DIM(DIM)) u_dpu (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl),
        .x_row(x_row), .wq_col(wq_col), .wk_col(wk_col), .wv_col(wv_col),
        .q_row(q_row), .k_row(k_row), .v_col(v_col), .s_row(s_row),
        .prod(out_data), .score(score)
    );

endmodule

//--- tb_sa_model.svh
// Attention reference model
`ifndef TB_SA_MODEL_SVH
`define TB_SA_MODEL_SVH

// Inputs of one job and its expected output
int     x_m  [DIM][DIM];
int     wq_m [DIM][DIM];
int     wk_m [DIM][DIM];
int     wv_m [DIM][DIM];
longint o_m  [DIM][DIM];
int     neg_dots;

// 16-bit Galois LFSR, one step
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic void run_model(input int t_rows);
    longint q [DIM][DIM];
    longint k [DIM][DIM];
    longint v [DIM][DIM];
    longint s [DIM][DIM];
    longint d;
    neg_dots = 0;
    for (int i = 0; i < DIM; i++) begin
        for (int j = 0; j < DIM; j++) begin
            q[i][j] = 0;
            k[i][j] = 0;
            v[i][j] = 0;
            // X rows at and beyond T count as zero
            for (int n = 0; n < DIM; n++) begin
                if (i < t_rows) begin
                    q[i][j] += longint'(x_m[i][n]) * longint'(wq_m[n][j]);
                    k[i][j] += longint'(x_m[i][n]) * longint'(wk_m[n][j]);
                    v[i][j] += longint'(x_m[i][n]) * longint'(wv_m[n][j]);
                end
            end
        end
    end
    for (int i = 0; i < DIM; i++) begin
        for (int j = 0; j < DIM; j++) begin
            s[i][j] = 0;
            if (i < t_rows && j < t_rows) begin
                d = 0;
                for (int n = 0; n < DIM; n++) begin
                    d += q[i][n] * k[j][n];
                end
                if (d < 0) begin
                    neg_dots++;
                end
                s[i][j] = (d < 0) ? 0 : d / 3;
            end
        end
    end
    for (int i = 0; i < DIM; i++) begin
        for (int j = 0; j < DIM; j++) begin
            o_m[i][j] = 0;
            for (int n = 0; n < DIM; n++) begin
                o_m[i][j] += s[i][n] * v[n][j];
            end
        end
    end
endfunction

`endif

//--- tb_sa.sv
// Attention engine testbench
`timescale 1ns/1ps

module tb_sa;
    import sa_cfg_pkg::*;
    import sa_types_pkg::*;

    localparam int DIM          = DIM_DEFAULT;
    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 8;
    // CALC_V, the largest SCORE and some margin
    localparam int OUT_WAIT     = 2 * DIM * DIM + 20;

    `include "tb_sa_model.svh"

    logic           clk = 1'b0;
    logic           rst_n;
    logic           in_valid;
    logic [T_W-1:0] t;
    elem_t          in_data;
    elem_t          w_q;
    elem_t          w_k;
    elem_t          w_v;
    logic           out_valid;
    out_t           out_data;

    logic [15:0] lfsr_state;
    string       test_name;
    int          tests_run = 0;
    int          tests_passed = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;

    sa_top #(.DIM(DIM)) UUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t(t),
        .in_data(in_data), .w_q(w_q), .w_k(w_k), .w_v(w_v),
        .out_valid(out_valid), .out_data(out_data)
    );

    always #CLK_HALF clk = ~clk;

    function automatic int rand_elem();
        logic [ELEM_W-1:0] b;
        b = '0;
        for (int i = 0; i < ELEM_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[ELEM_W-2:0], lfsr_state[0]};
        end
        return int'($signed(b));
    endfunction

    function automatic int job_cycles(input int t_rows);
        return 4 * DIM * DIM + t_rows * t_rows + DIM * t_rows + 20;
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string name, input longint got, input longint exp);
        checks++;
        assert (got == exp) else begin
            $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d %s: passed", tests_run, test_name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, test_name, test_errors);
        end
    endtask

    task automatic fill_random();
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                x_m[r][c]  = rand_elem();
                wq_m[r][c] = rand_elem();
                wk_m[r][c] = rand_elem();
                wv_m[r][c] = rand_elem();
            end
        end
    endtask

    // Three phases of DIM x DIM beats, row-major
    task automatic send_job(input int t_rows);
        int ph;
        int r;
        int c;
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b1;
        t = T_W'(t_rows);
        for (int k = 0; k < 3 * DIM * DIM; k++) begin
            ph = k / (DIM * DIM);
            r = (k % (DIM * DIM)) / DIM;
            c = k % DIM;
            in_data = (ph == 0) ? elem_t'(x_m[r][c]) : '0;
            w_q = (ph == 0) ? elem_t'(wq_m[r][c]) : '0;
            w_k = (ph == 1) ? elem_t'(wk_m[r][c]) : '0;
            w_v = (ph == 2) ? elem_t'(wv_m[r][c]) : '0;
            @(posedge clk);
            #DRIVE_DLY;
        end
        in_valid = 1'b0;
        t = '0;
        in_data = '0;
        w_q = '0;
        w_k = '0;
        w_v = '0;
    endtask

    task automatic collect_output(input int t_rows);
        int waited;
        int beats;
        waited = 0;
        beats = 0;
        @(negedge clk);
        while (!out_valid && waited < OUT_WAIT) begin
            check_value("out_data", out_data, 0);
            waited++;
            @(negedge clk);
        end
        if (!out_valid) begin
            $display("Output of the job with T=%0d did not start within %0d cycles",
                     t_rows, OUT_WAIT);
            note_error();
        end else begin
            while (out_valid) begin
                if (beats < t_rows * DIM) begin
                    check_value("out_data", out_data, o_m[beats / DIM][beats % DIM]);
                end
                beats++;
                @(negedge clk);
            end
            check_value("out_valid beat count", beats, t_rows * DIM);
        end
    endtask

    task automatic run_job(input int t_rows);
        run_model(t_rows);
        send_job(t_rows);
        collect_output(t_rows);
    endtask

    initial begin
        int limit;
        limit = 2 * (RESET_CYCLES + IDLE_CYCLES + job_cycles(8) + job_cycles(1)
                     + job_cycles(3) + job_cycles(8) + job_cycles(7) + job_cycles(2));
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d clock cycles", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        t = '0;
        in_data = '0;
        w_q = '0;
        w_k = '0;
        w_v = '0;
        lfsr_state = 16'd55;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        start_test("idle_after_reset");
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("out_data", out_data, 0);
        end
        end_test();

        start_test("full_rows_random");
        fill_random();
        run_job(8);
        end_test();

        start_test("single_row");
        fill_random();
        run_job(1);
        end_test();

        start_test("rows_beyond_t");
        fill_random();
        for (int r = 3; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                x_m[r][c] = (x_m[r][c] == 0) ? 77 : x_m[r][c];
            end
        end
        run_job(3);
        end_test();

        // K = -Q, so every diagonal score is negative
        start_test("negative_scores");
        fill_random();
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                wq_m[r][c] = (wq_m[r][c] == -128) ? -127 : wq_m[r][c];
                wk_m[r][c] = -wq_m[r][c];
            end
        end
        run_job(8);
        assert (neg_dots >= DIM) else begin
            $display("Negative score stimulus gave only %0d negative dot products", neg_dots);
            note_error();
        end
        end_test();

        start_test("back_to_back");
        fill_random();
        run_job(7);
        fill_random();
        run_job(2);
        end_test();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
sa_cfg_pkg.sv
sa_types_pkg.sv
matrix_store.sv
dot_product_unit.sv
sa_ctrl.sv
sa_top.sv
tb_sa.sv

//--- Makefile
TOP = tb_sa

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

.PHONY: help test clean
